//--- memtest_top.f
src/mem_pkg.sv
src/wb_pkg.sv
src/host_regs.sv
src/memtest.sv
src/scanout_dma.sv
src/mem_arbiter.sv
src/mem_sram.sv
src/memtest_top.sv
dv/memtest_top_tb.sv

//--- Bender.yml
package:
  name: memtest_top

sources:
  - src/mem_pkg.sv
  - src/wb_pkg.sv
  - src/host_regs.sv
  - src/memtest.sv
  - src/scanout_dma.sv
  - src/mem_arbiter.sv
  - src/mem_sram.sv
  - src/memtest_top.sv
  - target: test
    files:
      - dv/memtest_top_tb.sv

//--- dv/memtest_top_tb.sv
// Testbench for the memory test core: table-driven memtest bursts, buffer checks, DMA scanout
module memtest_top_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MEM_WORDS   = 1024;
	localparam int BUF_WORDS   = 16;
	localparam int HALF_PERIOD = 50;
	localparam int CLK_PERIOD  = 2 * HALF_PERIOD;
	localparam int DRIVE_DLY   = 10;
	localparam int RST_CYCLES  = 8;
	localparam int ACK_LIMIT   = 8;
	localparam int POLL_LIMIT  = 64;
	localparam int N_ROWS      = 7;
	localparam int SETUP_CYC   = 2000;
	localparam int TIMEOUT_CYC = N_ROWS * BUF_WORDS * 20 + SETUP_CYC;

	typedef struct packed {
		logic [31:0]               addr;
		logic [mem_pkg::LEN_W-1:0] len;
		logic                      check;
		logic                      flip;
		logic                      exp_mm;
	} row_t;

	// Columns: memory address, burst length, check read, flip one word, expected mismatch
	row_t rows [N_ROWS] = '{
		'{32'h0000_0000, 7'd15, 1'b1, 1'b0, 1'b0},
		'{32'h0000_0010, 7'd15, 1'b1, 1'b1, 1'b1},
		'{32'h0000_0020, 7'd7,  1'b0, 1'b0, 1'b0},
		'{32'h0000_0028, 7'd7,  1'b1, 1'b1, 1'b1},
		'{32'h0000_03f8, 7'd15, 1'b1, 1'b0, 1'b0},
		'{32'h0000_0100, 7'd0,  1'b1, 1'b0, 1'b0},
		'{32'h0000_0200, 7'd3,  1'b0, 1'b0, 1'b0}
	};

	logic                       clk;
	logic                       rst;
	logic [wb_pkg::WB_AW-1:0]   wb_addr;
	logic [wb_pkg::WB_DW-1:0]   wb_wdata;
	logic                       wb_we;
	logic                       wb_cyc;
	logic [wb_pkg::WB_DW-1:0]   wb_rdata;
	logic                       wb_ack;
	logic [mem_pkg::DATA_W-1:0] pix_data;
	logic                       pix_valid;
	logic                       frame_done;

	// Mirror of every completed write burst
	logic [31:0] ref_mem [MEM_WORDS];
	logic [31:0] exp_buf [BUF_WORDS];
	logic [31:0] lfsr = 32'h3751_77c6;

	int errors       = 0;
	int checks       = 0;
	int frame_base   = 0;
	int frame_words  = 0;
	int pix_cnt      = 0;
	int done_cnt     = 0;
	int cycle_no     = 0;
	int last_pix_cyc = 0;

	memtest_top #(
		.MEM_WORDS (MEM_WORDS),
		.BUF_WORDS (BUF_WORDS)
	) i_memtest_top (
		.clk_i        (clk),
		.rst_i        (rst),
		.wb_wdata_i   (wb_wdata),
		.wb_addr_i    (wb_addr),
		.wb_we_i      (wb_we),
		.wb_cyc_i     (wb_cyc),
		.wb_rdata_o   (wb_rdata),
		.wb_ack_o     (wb_ack),
		.pix_data_o   (pix_data),
		.pix_valid_o  (pix_valid),
		.frame_done_o (frame_done)
	);

	always #HALF_PERIOD clk = ~clk;

	// --------------------
	// Helpers
	// --------------------

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic rand_word(output logic [31:0] w);
		int b;
		w = '0;
		for (b = 0; b < 32; b++) begin
			lfsr = lfsr_step(lfsr);
			w = {w[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [wb_pkg::WB_AW-1:0] reg_addr(input int slv, input int ofs);
		logic [wb_pkg::WB_AW-1:0] a;
		a = '0;
		a[wb_pkg::SEL_MSB:wb_pkg::SEL_LSB] = slv[wb_pkg::SEL_W-1:0];
		a[wb_pkg::OFS_W-1:0] = ofs[wb_pkg::OFS_W-1:0];
		return a;
	endfunction

	function automatic logic [wb_pkg::WB_AW-1:0] buf_addr(input int idx);
		logic [wb_pkg::WB_AW-1:0] a;
		a = reg_addr(wb_pkg::SLV_MT, 0);
		a[wb_pkg::MT_BUF_BIT] = 1'b1;
		a[wb_pkg::MT_BUF_BIT-1:0] = idx[wb_pkg::MT_BUF_BIT-1:0];
		return a;
	endfunction

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// --------------------
	// Bus access
	// --------------------

	task automatic wait_ack();
		int n;
		n = 0;
		@(posedge clk);
		#DRIVE_DLY;
		while (!wb_ack && n < ACK_LIMIT) begin
			@(posedge clk);
			#DRIVE_DLY;
			n++;
		end
		if (!wb_ack) begin
			errors++;
			$display("bus access to %h got no ack at %0t ns", wb_addr, $time);
		end
	endtask

	task automatic bus_write(input logic [wb_pkg::WB_AW-1:0] addr, input logic [31:0] data);
		wb_addr  = addr;
		wb_wdata = data;
		wb_we    = 1'b1;
		wb_cyc   = 1'b1;
		wait_ack();
		wb_cyc = 1'b0;
		wb_we  = 1'b0;
		// Idle cycle between accesses
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic bus_read(input logic [wb_pkg::WB_AW-1:0] addr, output logic [31:0] data);
		wb_addr = addr;
		wb_we   = 1'b0;
		wb_cyc  = 1'b1;
		wait_ack();
		data   = wb_rdata;
		wb_cyc = 1'b0;
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	// --------------------
	// Memtest operations
	// --------------------

	task automatic fill_buffer(input int len);
		int i;
		logic [31:0] w;
		for (i = 0; i <= len; i++) begin
			rand_word(w);
			exp_buf[i] = w;
			bus_write(buf_addr(i), w);
		end
	endtask

	task automatic clear_buffer(input int len);
		int i;
		for (i = 0; i <= len; i++) begin
			exp_buf[i] = '0;
			bus_write(buf_addr(i), '0);
		end
	endtask

	task automatic verify_buffer(input int len);
		int i;
		logic [31:0] r;
		for (i = 0; i <= len; i++) begin
			bus_read(buf_addr(i), r);
			check_word("wb_rdata_o buffer word", r, exp_buf[i]);
		end
	endtask

	task automatic mirror_write(input logic [31:0] addr, input int len);
		int i;
		for (i = 0; i <= len; i++)
			ref_mem[(addr + i) % MEM_WORDS] = exp_buf[i];
	endtask

	task automatic load_expected(input logic [31:0] addr, input int len);
		int i;
		for (i = 0; i <= len; i++)
			exp_buf[i] = ref_mem[(addr + i) % MEM_WORDS];
	endtask

	task automatic start_burst(input logic [31:0] addr, input int len, input logic rd,
			input logic chk);
		logic [31:0] cmd;
		cmd = '0;
		cmd[mem_pkg::LEN_W-1:0] = len[mem_pkg::LEN_W-1:0];
		cmd[wb_pkg::CMD_RW_BIT] = rd;
		cmd[wb_pkg::CMD_CHK_BIT] = chk;
		cmd[wb_pkg::CMD_START_BIT] = 1'b1;
		bus_write(reg_addr(wb_pkg::SLV_MT, wb_pkg::MT_ADDR), addr);
		bus_write(reg_addr(wb_pkg::SLV_MT, wb_pkg::MT_CMD), cmd);
	endtask

	task automatic wait_idle(output logic [31:0] stat);
		int n;
		n = 0;
		bus_read(reg_addr(wb_pkg::SLV_MT, wb_pkg::MT_STAT), stat);
		while (stat[0] && n < POLL_LIMIT) begin
			bus_read(reg_addr(wb_pkg::SLV_MT, wb_pkg::MT_STAT), stat);
			n++;
		end
		if (stat[0]) begin
			errors++;
			$display("memtest busy never cleared, at %0t ns", $time);
		end
	endtask

	task automatic run_burst(input logic [31:0] addr, input int len, input logic rd,
			input logic chk, output logic [31:0] stat);
		start_burst(addr, len, rd, chk);
		wait_idle(stat);
	endtask

	task automatic run_row(input int r);
		row_t row;
		int k;
		logic [31:0] stat;
		row = rows[r];
		fill_buffer(row.len);
		verify_buffer(row.len);
		run_burst(row.addr, row.len, 1'b0, 1'b0, stat);
		check_word("wb_rdata_o MT_STAT", stat, 32'h0);
		mirror_write(row.addr, row.len);
		clear_buffer(row.len);
		run_burst(row.addr, row.len, 1'b1, 1'b0, stat);
		check_word("wb_rdata_o MT_STAT", stat, 32'h0);
		load_expected(row.addr, row.len);
		verify_buffer(row.len);
		if (row.check) begin
			if (row.flip) begin
				k = row.len / 2;
				exp_buf[k] = exp_buf[k] ^ 32'h0000_0001;
				bus_write(buf_addr(k), exp_buf[k]);
			end
			run_burst(row.addr, row.len, 1'b1, 1'b1, stat);
			check_word("wb_rdata_o MT_STAT", stat, {30'b0, row.exp_mm, 1'b0});
		end
	endtask

	// --------------------
	// Scanout
	// --------------------

	task automatic config_frame(input logic [31:0] base, input int len, input int lines);
		bus_write(reg_addr(wb_pkg::SLV_DMA, wb_pkg::DMA_BASE), base);
		bus_write(reg_addr(wb_pkg::SLV_DMA, wb_pkg::DMA_LINE_LEN), len);
		bus_write(reg_addr(wb_pkg::SLV_DMA, wb_pkg::DMA_LINES), lines);
		frame_base  = base;
		frame_words = lines * (len + 1);
		pix_cnt     = 0;
		done_cnt    = 0;
	endtask

	task automatic wait_frame();
		int n;
		int limit;
		logic [31:0] stat;
		n = 0;
		limit = frame_words * 8 + 200;
		while (done_cnt == 0 && n < limit) begin
			@(posedge clk);
			#DRIVE_DLY;
			n++;
		end
		if (done_cnt == 0) begin
			errors++;
			$display("frame_done_o never pulsed, at %0t ns", $time);
		end
		// Catch stray pixels or a second pulse
		repeat (4) begin
			@(posedge clk);
			#DRIVE_DLY;
		end
		check_word("pixel count", pix_cnt, frame_words);
		check_word("frame_done_o pulse count", done_cnt, 1);
		bus_read(reg_addr(wb_pkg::SLV_DMA, wb_pkg::DMA_STAT), stat);
		check_word("wb_rdata_o DMA_STAT", stat, 32'h0);
	endtask

	// Pixel stream against the mirror, sampled mid-cycle
	always @(negedge clk) begin
		cycle_no++;
		if (pix_valid) begin
			if (pix_cnt >= frame_words) begin
				errors++;
				$display("pixel beyond the end of the frame at %0t ns", $time);
			end else begin
				check_word("pix_data_o", pix_data, ref_mem[(frame_base + pix_cnt) % MEM_WORDS]);
			end
			pix_cnt++;
			last_pix_cyc = cycle_no;
		end
		if (frame_done) begin
			done_cnt++;
			if (pix_cnt != frame_words || cycle_no != last_pix_cyc + 1) begin
				errors++;
				$display("frame_done_o did not follow the last pixel, at %0t ns", $time);
			end
		end
	end

	task automatic overlap_test();
		logic [31:0] stat;
		config_frame(32'h0000_0020, 3, 4);
		fill_buffer(15);
		start_burst(32'h0000_0300, 15, 1'b0, 1'b0);
		// Lands while the write burst is still moving
		bus_write(reg_addr(wb_pkg::SLV_AUX, 0), 32'h1);
		mirror_write(32'h0000_0300, 15);
		wait_frame();
		wait_idle(stat);
		check_word("wb_rdata_o MT_STAT", stat, 32'h0);
		bus_write(reg_addr(wb_pkg::SLV_AUX, 0), 32'h0);
		clear_buffer(15);
		run_burst(32'h0000_0300, 15, 1'b1, 1'b0, stat);
		check_word("wb_rdata_o MT_STAT", stat, 32'h0);
		load_expected(32'h0000_0300, 15);
		verify_buffer(15);
	endtask

	// --------------------
	// Main sequence
	// --------------------

	initial begin
		int r;
		logic [31:0] rd;
		clk      = 1'b0;
		rst      = 1'b1;
		wb_addr  = '0;
		wb_wdata = '0;
		wb_we    = 1'b0;
		wb_cyc   = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;

		check_word("pix_valid_o", {31'b0, pix_valid}, 32'h0);
		check_word("frame_done_o", {31'b0, frame_done}, 32'h0);
		bus_read(reg_addr(wb_pkg::SLV_MT, wb_pkg::MT_STAT), rd);
		check_word("wb_rdata_o MT_STAT", rd, 32'h0);
		bus_read(reg_addr(wb_pkg::SLV_AUX, 0), rd);
		check_word("wb_rdata_o aux", rd, 32'h0);

		for (r = 0; r < N_ROWS; r++)
			run_row(r);

		// Frame over the first rows, including the wrapped burst
		config_frame(32'h0000_0000, 7, 4);
		bus_write(reg_addr(wb_pkg::SLV_AUX, 0), 32'h1);
		wait_frame();
		bus_write(reg_addr(wb_pkg::SLV_AUX, 0), 32'h0);

		overlap_test();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		#(TIMEOUT_CYC * CLK_PERIOD);
		$display("timeout after %0d cycles, run stopped", TIMEOUT_CYC);
		$display("checks %0d, errors %0d", checks, errors);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- src/memtest_top.sv
// Top level of the memory test core: bus decoder, memory tester, scanout DMA, arbiter and memory
module memtest_top #(
	parameter int MEM_WORDS = 1024,
	parameter int BUF_WORDS = 16
) (
	input  logic                         clk_i,
	input  logic                         rst_i,
	input  logic [wb_pkg::WB_DW-1:0]     wb_wdata_i,
	input  logic [wb_pkg::WB_AW-1:0]     wb_addr_i,
	input  logic                         wb_we_i,
	input  logic                         wb_cyc_i,
	output logic [wb_pkg::WB_DW-1:0]     wb_rdata_o,
	output logic                         wb_ack_o,
	output logic [mem_pkg::DATA_W-1:0]   pix_data_o,
	output logic                         pix_valid_o,
	output logic                         frame_done_o
);

	// Register bus
	logic [wb_pkg::N_SLAVES-1:0] slv_cyc;
	logic [wb_pkg::N_SLAVES-1:0] slv_ack;
	logic [wb_pkg::WB_DW-1:0]    slv_rdata [wb_pkg::N_SLAVES];
	logic                        dma_run;

	// Memory tester side
	logic [mem_pkg::ADDR_W-1:0]  mt_addr;
	logic [mem_pkg::LEN_W-1:0]   mt_len;
	logic                        mt_rw;
	logic                        mt_valid;
	logic                        mt_ready;
	logic [mem_pkg::DATA_W-1:0]  mt_wdata;
	logic                        mt_wack;
	logic [mem_pkg::DATA_W-1:0]  mt_rdata;
	logic                        mt_rstb;

	// DMA side, read only
	logic [mem_pkg::ADDR_W-1:0]  dma_addr;
	logic [mem_pkg::LEN_W-1:0]   dma_len;
	logic                        dma_rw;
	logic                        dma_valid;
	logic                        dma_ready;
	logic [mem_pkg::DATA_W-1:0]  dma_rdata;
	logic                        dma_rstb;

	// Memory side
	logic [mem_pkg::ADDR_W-1:0]  mi_addr;
	logic [mem_pkg::LEN_W-1:0]   mi_len;
	logic                        mi_rw;
	logic                        mi_valid;
	logic                        mi_ready;
	logic [mem_pkg::DATA_W-1:0]  mi_wdata;
	logic                        mi_wack;
	logic [mem_pkg::DATA_W-1:0]  mi_rdata;
	logic                        mi_rstb;

	// Aux slot is answered inside host_regs
	assign slv_ack[wb_pkg::SLV_AUX]   = 1'b0;
	assign slv_rdata[wb_pkg::SLV_AUX] = '0;

	// --------------------
	// Host side
	// --------------------

	host_regs i_host_regs (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.wb_addr_i   (wb_addr_i),
		.wb_wdata_i  (wb_wdata_i),
		.wb_we_i     (wb_we_i),
		.wb_cyc_i    (wb_cyc_i),
		.wb_rdata_o  (wb_rdata_o),
		.wb_ack_o    (wb_ack_o),
		.slv_cyc_o   (slv_cyc),
		.slv_ack_i   (slv_ack),
		.slv_rdata_i (slv_rdata),
		.dma_run_o   (dma_run)
	);

	// --------------------
	// Masters
	// --------------------

	memtest #(
		.BUF_WORDS (BUF_WORDS)
	) i_memtest (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.wb_addr_i  (wb_addr_i),
		.wb_wdata_i (wb_wdata_i),
		.wb_we_i    (wb_we_i),
		.wb_cyc_i   (slv_cyc[wb_pkg::SLV_MT]),
		.wb_rdata_o (slv_rdata[wb_pkg::SLV_MT]),
		.wb_ack_o   (slv_ack[wb_pkg::SLV_MT]),
		.mi_addr_o  (mt_addr),
		.mi_len_o   (mt_len),
		.mi_rw_o    (mt_rw),
		.mi_valid_o (mt_valid),
		.mi_ready_i (mt_ready),
		.mi_wdata_o (mt_wdata),
		.mi_wack_i  (mt_wack),
		.mi_rdata_i (mt_rdata),
		.mi_rstb_i  (mt_rstb)
	);

	scanout_dma i_scanout_dma (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.wb_addr_i    (wb_addr_i),
		.wb_wdata_i   (wb_wdata_i),
		.wb_we_i      (wb_we_i),
		.wb_cyc_i     (slv_cyc[wb_pkg::SLV_DMA]),
		.wb_rdata_o   (slv_rdata[wb_pkg::SLV_DMA]),
		.wb_ack_o     (slv_ack[wb_pkg::SLV_DMA]),
		.run_i        (dma_run),
		.mi_addr_o    (dma_addr),
		.mi_len_o     (dma_len),
		.mi_rw_o      (dma_rw),
		.mi_valid_o   (dma_valid),
		.mi_ready_i   (dma_ready),
		.mi_rdata_i   (dma_rdata),
		.mi_rstb_i    (dma_rstb),
		.pix_data_o   (pix_data_o),
		.pix_valid_o  (pix_valid_o),
		.frame_done_o (frame_done_o)
	);

	// --------------------
	// Memory
	// --------------------

	mem_arbiter i_mem_arbiter (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.sel_i      (dma_run),
		.m0_addr_i  (mt_addr),
		.m0_len_i   (mt_len),
		.m0_rw_i    (mt_rw),
		.m0_valid_i (mt_valid),
		.m0_ready_o (mt_ready),
		.m0_wdata_i (mt_wdata),
		.m0_wack_o  (mt_wack),
		.m0_rdata_o (mt_rdata),
		.m0_rstb_o  (mt_rstb),
		.m1_addr_i  (dma_addr),
		.m1_len_i   (dma_len),
		.m1_rw_i    (dma_rw),
		.m1_valid_i (dma_valid),
		.m1_ready_o (dma_ready),
		.m1_wdata_i ('0),
		.m1_wack_o  (),
		.m1_rdata_o (dma_rdata),
		.m1_rstb_o  (dma_rstb),
		.s_addr_o   (mi_addr),
		.s_len_o    (mi_len),
		.s_rw_o     (mi_rw),
		.s_valid_o  (mi_valid),
		.s_ready_i  (mi_ready),
		.s_wdata_o  (mi_wdata),
		.s_wack_i   (mi_wack),
		.s_rdata_i  (mi_rdata),
		.s_rstb_i   (mi_rstb)
	);

	mem_sram #(
		.MEM_WORDS (MEM_WORDS)
	) i_mem_sram (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.mi_addr_i  (mi_addr),
		.mi_len_i   (mi_len),
		.mi_rw_i    (mi_rw),
		.mi_valid_i (mi_valid),
		.mi_ready_o (mi_ready),
		.mi_wdata_i (mi_wdata),
		.mi_wack_o  (mi_wack),
		.mi_rdata_o (mi_rdata),
		.mi_rstb_o  (mi_rstb)
	);

endmodule

//--- src/mem_sram.sv
// On-chip word memory behind the memory interface, with fixed write ack and read strobe timing
module mem_sram #(
	parameter int MEM_WORDS = 1024
) (
	input  logic                         clk_i,
	input  logic                         rst_i,
	input  logic [mem_pkg::ADDR_W-1:0]   mi_addr_i,
	input  logic [mem_pkg::LEN_W-1:0]    mi_len_i,
	input  logic                         mi_rw_i,
	input  logic                         mi_valid_i,
	output logic                         mi_ready_o,
	input  logic [mem_pkg::DATA_W-1:0]   mi_wdata_i,
	output logic                         mi_wack_o,
	output logic [mem_pkg::DATA_W-1:0]   mi_rdata_o,
	output logic                         mi_rstb_o
);

	localparam int AW = $clog2(MEM_WORDS);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WR,
		ST_RD
	} state_t;

	state_t                     state;
	logic [mem_pkg::DATA_W-1:0] mem [MEM_WORDS];
	// Low address bits only, so bursts wrap at the top
	logic [AW-1:0]              addr_q;
	logic [mem_pkg::LEN_W-1:0]  len_q;
	logic [mem_pkg::LEN_W-1:0]  cnt;
	logic [3:0]                 dly;
	logic                       rd_go;

	// Not ready while the last read word is still on its way out
	assign mi_ready_o = (state == ST_IDLE) & ~mi_rstb_o;
	assign mi_wack_o  = (state == ST_WR);
	assign rd_go      = (state == ST_RD) & (dly == '0);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state     <= ST_IDLE;
			mi_rstb_o <= 1'b0;
		end else begin
			mi_rstb_o <= rd_go;
			case (state)
				ST_IDLE:
					if (mi_valid_i & mi_ready_o)
						state <= (mi_rw_i == mem_pkg::RW_WRITE) ? ST_WR : ST_RD;
				ST_WR:
					if (cnt == len_q)
						state <= ST_IDLE;
				ST_RD:
					if (rd_go & (cnt == len_q))
						state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Request capture and word array
	always_ff @(posedge clk_i) begin
		if (state == ST_IDLE) begin
			addr_q <= mi_addr_i[AW-1:0];
			len_q  <= mi_len_i;
			cnt    <= '0;
			dly    <= 4'(mem_pkg::RD_LAT - 2);
		end
		if ((state == ST_RD) && (dly != '0))
			dly <= dly - 1'b1;
		if (mi_wack_o)
			mem[addr_q] <= mi_wdata_i;
		if (rd_go)
			mi_rdata_o <= mem[addr_q];
		if (mi_wack_o | rd_go) begin
			addr_q <= addr_q + 1'b1;
			cnt    <= cnt + 1'b1;
		end
	end

endmodule

//--- src/mem_arbiter.sv
// Two-master memory arbiter that only moves the grant between bursts
module mem_arbiter (
	input  logic                         clk_i,
	input  logic                         rst_i,
	input  logic                         sel_i,
	input  logic [mem_pkg::ADDR_W-1:0]   m0_addr_i,
	input  logic [mem_pkg::LEN_W-1:0]    m0_len_i,
	input  logic                         m0_rw_i,
	input  logic                         m0_valid_i,
	output logic                         m0_ready_o,
	input  logic [mem_pkg::DATA_W-1:0]   m0_wdata_i,
	output logic                         m0_wack_o,
	output logic [mem_pkg::DATA_W-1:0]   m0_rdata_o,
	output logic                         m0_rstb_o,
	input  logic [mem_pkg::ADDR_W-1:0]   m1_addr_i,
	input  logic [mem_pkg::LEN_W-1:0]    m1_len_i,
	input  logic                         m1_rw_i,
	input  logic                         m1_valid_i,
	output logic                         m1_ready_o,
	input  logic [mem_pkg::DATA_W-1:0]   m1_wdata_i,
	output logic                         m1_wack_o,
	output logic [mem_pkg::DATA_W-1:0]   m1_rdata_o,
	output logic                         m1_rstb_o,
	output logic [mem_pkg::ADDR_W-1:0]   s_addr_o,
	output logic [mem_pkg::LEN_W-1:0]    s_len_o,
	output logic                         s_rw_o,
	output logic                         s_valid_o,
	input  logic                         s_ready_i,
	output logic [mem_pkg::DATA_W-1:0]   s_wdata_o,
	input  logic                         s_wack_i,
	input  logic [mem_pkg::DATA_W-1:0]   s_rdata_i,
	input  logic                         s_rstb_i
);

	logic                     gnt;
	logic                     accept;
	// Words still owed by the memory for the accepted burst
	logic [mem_pkg::LEN_W:0]  pend;

	assign accept = s_valid_o & s_ready_i;

	assign s_addr_o  = gnt ? m1_addr_i  : m0_addr_i;
	assign s_len_o   = gnt ? m1_len_i   : m0_len_i;
	assign s_rw_o    = gnt ? m1_rw_i    : m0_rw_i;
	assign s_valid_o = gnt ? m1_valid_i : m0_valid_i;
	assign s_wdata_o = gnt ? m1_wdata_i : m0_wdata_i;

	assign m0_ready_o = s_ready_i & ~gnt;
	assign m1_ready_o = s_ready_i & gnt;
	assign m0_wack_o  = s_wack_i & ~gnt;
	assign m1_wack_o  = s_wack_i & gnt;
	assign m0_rstb_o  = s_rstb_i & ~gnt;
	assign m1_rstb_o  = s_rstb_i & gnt;
	assign m0_rdata_o = s_rdata_i;
	assign m1_rdata_o = s_rdata_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			gnt  <= 1'b0;
			pend <= '0;
		end else begin
			if (accept)
				pend <= {1'b0, s_len_o} + 1'b1;
			else if (s_wack_i | s_rstb_i)
				pend <= pend - 1'b1;
			if ((pend == '0) && !accept)
				gnt <= sel_i;
		end
	end

endmodule

//--- src/scanout_dma.sv
// Scanout DMA: reads a frame line by line from memory and emits each word as one pixel
module scanout_dma (
	input  logic                         clk_i,
	input  logic                         rst_i,
	input  logic [wb_pkg::WB_AW-1:0]     wb_addr_i,
	input  logic [wb_pkg::WB_DW-1:0]     wb_wdata_i,
	input  logic                         wb_we_i,
	input  logic                         wb_cyc_i,
	output logic [wb_pkg::WB_DW-1:0]     wb_rdata_o,
	output logic                         wb_ack_o,
	input  logic                         run_i,
	output logic [mem_pkg::ADDR_W-1:0]   mi_addr_o,
	output logic [mem_pkg::LEN_W-1:0]    mi_len_o,
	output logic                         mi_rw_o,
	output logic                         mi_valid_o,
	input  logic                         mi_ready_i,
	input  logic [mem_pkg::DATA_W-1:0]   mi_rdata_i,
	input  logic                         mi_rstb_i,
	output logic [mem_pkg::DATA_W-1:0]   pix_data_o,
	output logic                         pix_valid_o,
	output logic                         frame_done_o
);

	localparam int LINES_W = 16;

	logic [mem_pkg::ADDR_W-1:0] base_q;
	logic [mem_pkg::ADDR_W-1:0] line_addr;
	logic [mem_pkg::LEN_W-1:0]  line_len_q;
	logic [mem_pkg::LEN_W-1:0]  wcnt;
	logic [LINES_W-1:0]         lines_q;
	logic [LINES_W-1:0]         line_cnt;
	logic [wb_pkg::OFS_W-1:0]   ofs;
	logic [wb_pkg::WB_DW-1:0]   reg_rdata;
	logic                       busy_q;
	logic                       run_d;
	logic                       bus_stb;
	logic                       bus_wr;
	logic                       start;
	logic                       last_word;

	assign bus_stb   = wb_cyc_i & ~wb_ack_o;
	assign bus_wr    = bus_stb & wb_we_i & ~busy_q;
	assign ofs       = wb_addr_i[wb_pkg::OFS_W-1:0];
	assign start     = run_i & ~run_d & ~busy_q & (lines_q != '0);
	assign last_word = mi_rstb_i & (wcnt == line_len_q);

	assign mi_addr_o   = line_addr;
	assign mi_len_o    = line_len_q;
	assign mi_rw_o     = mem_pkg::RW_READ;
	assign pix_data_o  = mi_rdata_i;
	assign pix_valid_o = mi_rstb_i;

	// --------------------
	// Frame sequencer
	// --------------------

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wb_ack_o     <= 1'b0;
			run_d        <= 1'b0;
			busy_q       <= 1'b0;
			mi_valid_o   <= 1'b0;
			frame_done_o <= 1'b0;
			wcnt         <= '0;
			line_cnt     <= '0;
		end else begin
			wb_ack_o     <= bus_stb;
			run_d        <= run_i;
			frame_done_o <= 1'b0;
			if (start) begin
				busy_q     <= 1'b1;
				mi_valid_o <= 1'b1;
				wcnt       <= '0;
				line_cnt   <= '0;
			end
			if (mi_valid_o & mi_ready_i)
				mi_valid_o <= 1'b0;
			if (mi_rstb_i)
				wcnt <= wcnt + 1'b1;
			if (last_word) begin
				wcnt     <= '0;
				line_cnt <= line_cnt + 1'b1;
				if (line_cnt == lines_q - 1'b1) begin
					busy_q       <= 1'b0;
					frame_done_o <= 1'b1;
				end else begin
					mi_valid_o <= 1'b1;
				end
			end
		end
	end

	// --------------------
	// Registers
	// --------------------

	always_ff @(posedge clk_i) begin
		if (start)
			line_addr <= base_q;
		else if (last_word)
			line_addr <= line_addr + mem_pkg::ADDR_W'(line_len_q) + 1'b1;
		if (bus_wr) begin
			case (ofs)
				wb_pkg::DMA_BASE:     base_q     <= wb_wdata_i;
				wb_pkg::DMA_LINE_LEN: line_len_q <= wb_wdata_i[mem_pkg::LEN_W-1:0];
				wb_pkg::DMA_LINES:    lines_q    <= wb_wdata_i[LINES_W-1:0];
				default: ;
			endcase
		end
		wb_rdata_o <= reg_rdata;
	end

	always_comb begin
		reg_rdata = '0;
		case (ofs)
			wb_pkg::DMA_BASE:     reg_rdata = base_q;
			wb_pkg::DMA_LINE_LEN: reg_rdata[mem_pkg::LEN_W-1:0] = line_len_q;
			wb_pkg::DMA_LINES:    reg_rdata[LINES_W-1:0] = lines_q;
			wb_pkg::DMA_STAT:     reg_rdata[0] = busy_q;
			default: ;
		endcase
	end

endmodule

//--- src/memtest.sv
// Memory tester: bus-loaded word buffer sent to or filled from memory in bursts, with read compare
module memtest #(
	parameter int BUF_WORDS = 16
) (
	input  logic                         clk_i,
	input  logic                         rst_i,
	input  logic [wb_pkg::WB_AW-1:0]     wb_addr_i,
	input  logic [wb_pkg::WB_DW-1:0]     wb_wdata_i,
	input  logic                         wb_we_i,
	input  logic                         wb_cyc_i,
	output logic [wb_pkg::WB_DW-1:0]     wb_rdata_o,
	output logic                         wb_ack_o,
	output logic [mem_pkg::ADDR_W-1:0]   mi_addr_o,
	output logic [mem_pkg::LEN_W-1:0]    mi_len_o,
	output logic                         mi_rw_o,
	output logic                         mi_valid_o,
	input  logic                         mi_ready_i,
	output logic [mem_pkg::DATA_W-1:0]   mi_wdata_o,
	input  logic                         mi_wack_i,
	input  logic [mem_pkg::DATA_W-1:0]   mi_rdata_i,
	input  logic                         mi_rstb_i
);

	localparam int BW = $clog2(BUF_WORDS);

	logic [mem_pkg::DATA_W-1:0] buf_mem [BUF_WORDS];
	logic [BW-1:0]              ptr;
	logic [BW-1:0]              buf_idx;
	logic [mem_pkg::LEN_W-1:0]  cnt;
	logic [mem_pkg::ADDR_W-1:0] addr_q;
	logic [mem_pkg::LEN_W-1:0]  len_q;
	logic                       rw_q;
	logic                       check_q;
	logic                       busy_q;
	logic                       mismatch_q;
	logic [wb_pkg::OFS_W-1:0]   ofs;
	logic [wb_pkg::WB_DW-1:0]   reg_rdata;
	logic                       bus_stb;
	logic                       bus_wr;
	logic                       buf_sel;
	logic                       cmd_wr;
	logic                       start;
	logic                       xfer;

	assign bus_stb = wb_cyc_i & ~wb_ack_o;
	assign bus_wr  = bus_stb & wb_we_i;
	assign buf_sel = wb_addr_i[wb_pkg::MT_BUF_BIT];
	assign buf_idx = wb_addr_i[BW-1:0];
	assign ofs     = wb_addr_i[wb_pkg::OFS_W-1:0];

	// Commands are ignored while a burst runs
	assign cmd_wr = bus_wr & ~buf_sel & (ofs == wb_pkg::MT_CMD) & ~busy_q;
	assign start  = cmd_wr & wb_wdata_i[wb_pkg::CMD_START_BIT];
	assign xfer   = mi_wack_i | mi_rstb_i;

	assign mi_addr_o  = addr_q;
	assign mi_len_o   = len_q;
	assign mi_rw_o    = rw_q;
	assign mi_wdata_o = buf_mem[ptr];

	// --------------------
	// Burst engine
	// --------------------

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wb_ack_o   <= 1'b0;
			mi_valid_o <= 1'b0;
			busy_q     <= 1'b0;
			mismatch_q <= 1'b0;
			ptr        <= '0;
			cnt        <= '0;
		end else begin
			wb_ack_o <= bus_stb;
			if (start) begin
				busy_q     <= 1'b1;
				mismatch_q <= 1'b0;
				mi_valid_o <= 1'b1;
				ptr        <= '0;
				cnt        <= '0;
			end
			if (mi_valid_o & mi_ready_i)
				mi_valid_o <= 1'b0;
			if (xfer) begin
				ptr <= ptr + 1'b1;
				cnt <= cnt + 1'b1;
				if (cnt == len_q)
					busy_q <= 1'b0;
			end
			// Sticky until the next start
			if (mi_rstb_i & check_q & (mi_rdata_i != buf_mem[ptr]))
				mismatch_q <= 1'b1;
		end
	end

	// --------------------
	// Registers and buffer
	// --------------------

	always_ff @(posedge clk_i) begin
		if (bus_wr & ~buf_sel & (ofs == wb_pkg::MT_ADDR) & ~busy_q)
			addr_q <= wb_wdata_i;
		if (cmd_wr) begin
			len_q   <= wb_wdata_i[mem_pkg::LEN_W-1:0];
			rw_q    <= wb_wdata_i[wb_pkg::CMD_RW_BIT];
			check_q <= wb_wdata_i[wb_pkg::CMD_CHK_BIT];
		end
		if (bus_wr & buf_sel)
			buf_mem[buf_idx] <= wb_wdata_i;
		if (mi_rstb_i & ~check_q)
			buf_mem[ptr] <= mi_rdata_i;
		wb_rdata_o <= reg_rdata;
	end

	always_comb begin
		reg_rdata = '0;
		if (buf_sel) begin
			reg_rdata = buf_mem[buf_idx];
		end else begin
			case (ofs)
				wb_pkg::MT_ADDR: reg_rdata = addr_q;
				wb_pkg::MT_CMD: begin
					reg_rdata[mem_pkg::LEN_W-1:0]   = len_q;
					reg_rdata[wb_pkg::CMD_RW_BIT]  = rw_q;
					reg_rdata[wb_pkg::CMD_CHK_BIT] = check_q;
				end
				wb_pkg::MT_STAT: reg_rdata[1:0] = {mismatch_q, busy_q};
				default: ;
			endcase
		end
	end

endmodule

//--- src/host_regs.sv
// Register bus decoder with per-slave cyc, ack and read data return, plus the aux control register
module host_regs (
	input  logic                          clk_i,
	input  logic                          rst_i,
	input  logic [wb_pkg::WB_AW-1:0]      wb_addr_i,
	input  logic [wb_pkg::WB_DW-1:0]      wb_wdata_i,
	input  logic                          wb_we_i,
	input  logic                          wb_cyc_i,
	output logic [wb_pkg::WB_DW-1:0]      wb_rdata_o,
	output logic                          wb_ack_o,
	output logic [wb_pkg::N_SLAVES-1:0]   slv_cyc_o,
	input  logic [wb_pkg::N_SLAVES-1:0]   slv_ack_i,
	input  logic [wb_pkg::WB_DW-1:0]      slv_rdata_i [wb_pkg::N_SLAVES],
	output logic                          dma_run_o
);

	logic [wb_pkg::SEL_W-1:0] sel;
	logic [wb_pkg::WB_DW-1:0] aux_q;
	logic                     aux_ack;

	assign sel = wb_addr_i[wb_pkg::SEL_MSB:wb_pkg::SEL_LSB];

	// --------------------
	// Aux register
	// --------------------

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			aux_q   <= '0;
			aux_ack <= 1'b0;
		end else begin
			aux_ack <= slv_cyc_o[wb_pkg::SLV_AUX] & ~aux_ack;
			if (slv_cyc_o[wb_pkg::SLV_AUX] & ~aux_ack & wb_we_i)
				aux_q <= wb_wdata_i;
		end
	end

	// Bit 0 hands the memory to the video side
	assign dma_run_o = aux_q[0];

	// --------------------
	// Decode and return
	// --------------------

	always_comb begin
		wb_rdata_o = '0;
		wb_ack_o   = 1'b0;
		for (int i = 0; i < wb_pkg::N_SLAVES; i++) begin
			slv_cyc_o[i] = wb_cyc_i && (sel == i);
			if (sel == i) begin
				wb_rdata_o = slv_rdata_i[i];
				wb_ack_o   = slv_ack_i[i];
			end
		end
		// Slot 0 also carries the local register
		if (sel == wb_pkg::SLV_AUX) begin
			wb_rdata_o = wb_rdata_o | aux_q;
			wb_ack_o   = wb_ack_o | aux_ack;
		end
	end

endmodule

//--- src/wb_pkg.sv
// Register bus widths, slave select field and register map, used by every bus slave and the top
package wb_pkg;

	localparam int WB_AW    = 11;
	localparam int WB_DW    = 32;
	localparam int N_SLAVES = 3;

	// Slave select in the upper address bits
	localparam int SEL_MSB = 10;
	localparam int SEL_LSB = 9;
	localparam int SEL_W   = SEL_MSB - SEL_LSB + 1;

	localparam int SLV_AUX = 0;
	localparam int SLV_MT  = 1;
	localparam int SLV_DMA = 2;

	// --------------------
	// Register offsets
	// --------------------

	localparam int OFS_W = 2;

	// Memory tester
	localparam logic [OFS_W-1:0] MT_ADDR = 2'd0;
	localparam logic [OFS_W-1:0] MT_CMD  = 2'd1;
	localparam logic [OFS_W-1:0] MT_STAT = 2'd2;
	localparam int MT_BUF_BIT    = 8;
	localparam int CMD_RW_BIT    = 8;
	localparam int CMD_CHK_BIT   = 9;
	localparam int CMD_START_BIT = 15;

	// Scanout DMA
	localparam logic [OFS_W-1:0] DMA_BASE     = 2'd0;
	localparam logic [OFS_W-1:0] DMA_LINE_LEN = 2'd1;
	localparam logic [OFS_W-1:0] DMA_LINES    = 2'd2;
	localparam logic [OFS_W-1:0] DMA_STAT     = 2'd3;

endpackage

//--- src/mem_pkg.sv
// Memory interface widths and burst encoding, used by both masters, the arbiter and the memory
package mem_pkg;

	// --------------------
	// Word sizes
	// --------------------

	// Word address, not byte address
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// Burst length field, value n moves n+1 words
	localparam int LEN_W = 7;

	// --------------------
	// Timing and encoding
	// --------------------

	// From request accept to the first read strobe
	localparam int RD_LAT = 2;

	// Direction carried on rw
	localparam logic RW_WRITE = 1'b0;
	localparam logic RW_READ  = 1'b1;

endpackage
